/* line_code_pkg.sv */
package line_code_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths of the 64b/66b receive path

	// Parallel word from the transceiver
	localparam int RX_WORD_W = 32;

	// Half of a 66-bit block, as produced by the gearbox
	localparam int HALF_W = 33;

	// Sync header and block body
	localparam int SH_W      = 2;
	localparam int PAYLOAD_W = 64;
	localparam int BLOCK_W   = SH_W + PAYLOAD_W;

	typedef logic [RX_WORD_W-1:0] rx_word_t;
	typedef logic [HALF_W-1:0]    half_block_t;
	typedef logic [SH_W-1:0]      sync_header_t;
	typedef logic [PAYLOAD_W-1:0] payload_t;
	typedef logic [BLOCK_W-1:0]   line_block_t;

	//////////////////////////////////////////////////////////////////////
	// Sync header values

	// Data block
	localparam sync_header_t SH_DATA = 2'b01;
	// Control block
	localparam sync_header_t SH_CTRL = 2'b10;

	//////////////////////////////////////////////////////////////////////
	// Scrambler x^58 + x^39 + 1

	localparam int SCRAMBLER_LEN = 58;
	localparam int SCRAMBLER_TAP = 39;

	// Descrambled block with its strobe
	typedef struct packed {
		logic         valid;
		sync_header_t header;
		payload_t     payload;
	} rx_block_t;

endpackage

/* block_sync_pkg.sv */
package block_sync_pkg;

	//////////////////////////////////////////////////////////////////////
	// Block lock FSM

	typedef enum logic [1:0] {
		// Waiting for the first block out of the pipeline
		LOCK_INIT,
		// Counting good headers toward lock
		LOCK_HUNT,
		// Letting blocks from before a bitslip drain
		LOCK_SLIP_WAIT,
		// Aligned, watching the bad header rate
		LOCK_LOCKED
	} lock_state_t;

	//////////////////////////////////////////////////////////////////////
	// Default thresholds

	// Good headers in a row before lock
	localparam int DEFAULT_GOOD_FOR_LOCK = 64;
	// Bad headers per 64-block window that drop lock
	localparam int DEFAULT_BAD_LIMIT = 16;
	// Blocks ignored after each slip
	localparam int DEFAULT_SLIP_WAIT = 4;

endpackage

/* rx_gearbox.sv */
`timescale 1ns/10ps

module rx_gearbox (
	input  logic                       lane0_rxclk,
	input  logic                       arst_n,
	input  line_code_pkg::rx_word_t    rx_data,
	input  logic                       slip,
	output line_code_pkg::half_block_t half_data,
	output logic                       half_valid
);
	import line_code_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Sizes

	// Leftover bits plus one new word
	localparam int WORK_W = RX_WORD_W + RX_WORD_W;

	// Leftover never exceeds one word
	localparam int FILL_W = $clog2(RX_WORD_W + 1);

	// Holds the bit count of the whole work vector
	localparam int AVAIL_W = $clog2(WORK_W + 1);

	//////////////////////////////////////////////////////////////////////
	// Bit buffer
	//
	// Valid bits sit at the bottom of the buffer, oldest bit highest.
	// The stream is MSB first, so the oldest bit becomes the MSB of the
	// next half-block

	// Leftover bits, only the low fill_q bits mean anything
	rx_word_t           held_q;
	logic [FILL_W-1:0]  fill_q;

	// Leftover on top, new word below
	logic [WORK_W-1:0]  work;

	// Bits usable this cycle after an optional slip
	logic [AVAIL_W-1:0] avail;

	// Right shift that brings the oldest 33 bits to the bottom
	logic [AVAIL_W-1:0] shift_amt;
	logic [WORK_W-1:0]  shifted;

	// A full half-block is available
	logic               emit;

	always_comb begin
		work = {held_q, rx_data};

		// Slip forgets the oldest held bit by not counting it
		avail = AVAIL_W'(fill_q) + AVAIL_W'(RX_WORD_W) - AVAIL_W'(slip);

		emit = (avail >= AVAIL_W'(HALF_W));

		// Only meaningful when emit is set
		shift_amt = avail - AVAIL_W'(HALF_W);
		shifted   = work >> shift_amt;
	end

	//////////////////////////////////////////////////////////////////////
	// Fill count and output strobe

	// Low for one cycle out of 33, one more per slip
	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			fill_q     <= '0;
			half_valid <= 1'b0;
		end else begin
			half_valid <= emit;

			// What is left after taking 33 bits, or everything
			if (emit) begin
				fill_q <= FILL_W'(shift_amt);
			end else begin
				fill_q <= FILL_W'(avail);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path

	always_ff @(posedge lane0_rxclk) begin
		// Newest word always kept, fill_q says how many bits count
		held_q <= rx_data;

		if (emit) begin
			half_data <= shifted[HALF_W-1:0];
		end
	end

endmodule

/* half_block_assembler.sv */
`timescale 1ns/10ps

module half_block_assembler (
	input  logic                       lane0_rxclk,
	input  logic                       arst_n,
	input  line_code_pkg::half_block_t half_data,
	input  logic                       half_valid,
	output line_code_pkg::line_block_t blk_raw,
	output logic                       blk_valid
);
	import line_code_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Pairing phase
	//
	// 0 means the next half is the first of a block.
	// Slip does not touch this; a wrong pairing just gives bad headers
	// and block sync keeps slipping until it lines up

	logic phase_q;

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			phase_q   <= 1'b0;
			blk_valid <= 1'b0;
		end else begin
			// Strobe in the cycle after the second half lands
			blk_valid <= half_valid && phase_q;

			if (half_valid) begin
				phase_q <= !phase_q;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Block register

	// First half carries the header, so it goes on top
	always_ff @(posedge lane0_rxclk) begin
		if (half_valid) begin
			if (phase_q) begin
				// Second half, completes the block
				blk_raw[HALF_W-1:0] <= half_data;
			end else begin
				// First half
				blk_raw[BLOCK_W-1:HALF_W] <= half_data;
			end
		end
	end

endmodule

/* block_sync.sv */
`timescale 1ns/10ps

module block_sync #(
	parameter int GOOD_FOR_LOCK = block_sync_pkg::DEFAULT_GOOD_FOR_LOCK,
	parameter int BAD_LIMIT     = block_sync_pkg::DEFAULT_BAD_LIMIT,
	parameter int SLIP_WAIT     = block_sync_pkg::DEFAULT_SLIP_WAIT
) (
	input  logic                       lane0_rxclk,
	input  logic                       arst_n,
	input  line_code_pkg::line_block_t blk_raw,
	input  logic                       blk_valid,
	output logic                       slip,
	output logic                       block_lock
);
	import line_code_pkg::*;
	import block_sync_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Counter sizes

	// Bad header window while locked
	localparam int WINDOW_LEN = 64;

	localparam int GOOD_W = $clog2(GOOD_FOR_LOCK + 1);
	localparam int BAD_W  = $clog2(BAD_LIMIT + 1);
	localparam int WAIT_W = $clog2(SLIP_WAIT + 1);
	localparam int WIN_W  = $clog2(WINDOW_LEN);

	lock_state_t       state_q;

	// Good headers in a row while hunting
	logic [GOOD_W-1:0] good_cnt_q;
	// Bad headers in the current window
	logic [BAD_W-1:0]  bad_cnt_q;
	// Blocks skipped since the last slip
	logic [WAIT_W-1:0] wait_cnt_q;
	// Position in the window, wraps by itself
	logic [WIN_W-1:0]  win_cnt_q;

	//////////////////////////////////////////////////////////////////////
	// Header check

	sync_header_t hdr;
	logic         hdr_ok;

	// Only 01 and 10 are legal, 00 and 11 mean misalignment or errors
	always_comb begin
		hdr    = blk_raw[BLOCK_W-1 -: SH_W];
		hdr_ok = (hdr == SH_DATA) || (hdr == SH_CTRL);
	end

	//////////////////////////////////////////////////////////////////////
	// Lock FSM

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= LOCK_INIT;
			good_cnt_q <= '0;
			bad_cnt_q  <= '0;
			wait_cnt_q <= '0;
			win_cnt_q  <= '0;
			slip       <= 1'b0;
			block_lock <= 1'b0;
		end else begin
			// Single-cycle pulse
			slip <= 1'b0;

			case (state_q)
				// First block may hold bits from before the stream, skip it
				LOCK_INIT: begin
					good_cnt_q <= '0;
					if (blk_valid) begin
						state_q <= LOCK_HUNT;
					end
				end

				LOCK_HUNT: begin
					if (blk_valid) begin
						if (!hdr_ok) begin
							// Wrong alignment, move one bit and start over
							slip       <= 1'b1;
							good_cnt_q <= '0;
							wait_cnt_q <= '0;
							state_q    <= LOCK_SLIP_WAIT;
						end else if (good_cnt_q == GOOD_W'(GOOD_FOR_LOCK - 1)) begin
							block_lock <= 1'b1;
							bad_cnt_q  <= '0;
							win_cnt_q  <= '0;
							state_q    <= LOCK_LOCKED;
						end else begin
							good_cnt_q <= good_cnt_q + 1'b1;
						end
					end
				end

				// Blocks in flight still have the old alignment
				LOCK_SLIP_WAIT: begin
					if (blk_valid) begin
						if (wait_cnt_q == WAIT_W'(SLIP_WAIT - 1)) begin
							state_q <= LOCK_HUNT;
						end else begin
							wait_cnt_q <= wait_cnt_q + 1'b1;
						end
					end
				end

				LOCK_LOCKED: begin
					if (blk_valid) begin
						win_cnt_q <= win_cnt_q + 1'b1;

						if (!hdr_ok && (bad_cnt_q == BAD_W'(BAD_LIMIT - 1))) begin
							// Too many errors, lock lost
							block_lock <= 1'b0;
							slip       <= 1'b1;
							good_cnt_q <= '0;
							wait_cnt_q <= '0;
							state_q    <= LOCK_SLIP_WAIT;
						end else if (win_cnt_q == WIN_W'(WINDOW_LEN - 1)) begin
							// End of window, new count
							bad_cnt_q <= '0;
						end else if (!hdr_ok) begin
							bad_cnt_q <= bad_cnt_q + 1'b1;
						end
					end
				end

				default: begin
					state_q <= LOCK_INIT;
				end
			endcase
		end
	end

endmodule

/* descrambler.sv */
`timescale 1ns/10ps

module descrambler (
	input  logic                       lane0_rxclk,
	input  logic                       arst_n,
	input  line_code_pkg::line_block_t blk_raw,
	input  logic                       blk_valid,
	output line_code_pkg::rx_block_t   rx_block
);
	import line_code_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Self-synchronizing descrambler, x^58 + x^39 + 1
	//
	// History holds received scrambled bits, bit 0 the most recent.
	// out = in ^ in(t-39) ^ in(t-58)

	// History carried from block to block
	logic [SCRAMBLER_LEN-1:0] state_q;

	// Running history inside the block
	logic [SCRAMBLER_LEN-1:0] hist;

	payload_t                 scrambled;
	payload_t                 descr;

	always_comb begin
		scrambled = blk_raw[PAYLOAD_W-1:0];
		hist      = state_q;

		// LSB is the first payload bit in scrambler order
		for (int i = 0; i < PAYLOAD_W; i++) begin
			descr[i] = scrambled[i] ^ hist[SCRAMBLER_TAP-1] ^ hist[SCRAMBLER_LEN-1];

			// Feed back the received bit, not the output
			hist = {hist[SCRAMBLER_LEN-2:0], scrambled[i]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	// One cycle after blk_valid, header untouched
	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			state_q  <= '0;
			rx_block <= '0;
		end else begin
			rx_block.valid <= blk_valid;

			if (blk_valid) begin
				state_q          <= hist;
				rx_block.header  <= blk_raw[BLOCK_W-1 -: SH_W];
				rx_block.payload <= descr;
			end
		end
	end

endmodule

/* rx_64b66b_top.sv */
`timescale 1ns/10ps

module rx_64b66b_top #(
	parameter int GOOD_FOR_LOCK = block_sync_pkg::DEFAULT_GOOD_FOR_LOCK,
	parameter int BAD_LIMIT     = block_sync_pkg::DEFAULT_BAD_LIMIT,
	parameter int SLIP_WAIT     = block_sync_pkg::DEFAULT_SLIP_WAIT
) (
	input  logic                     lane0_rxclk,
	input  logic                     arst_n,
	input  line_code_pkg::rx_word_t  rx_data,
	output logic                     block_lock,
	output line_code_pkg::rx_block_t rx_block
);
	import line_code_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// 32 to 33 gearbox
	//
	// Two steps, 32:33 then 33:66, keep the mux tree small

	half_block_t half_data;
	logic        half_valid;
	logic        slip;

	rx_gearbox i_rx_gearbox (
		.lane0_rxclk (lane0_rxclk),
		.arst_n      (arst_n),
		.rx_data     (rx_data),
		.slip        (slip),
		.half_data   (half_data),
		.half_valid  (half_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// 33 to 66 pairing

	line_block_t blk_raw;
	logic        blk_valid;

	half_block_assembler i_half_block_assembler (
		.lane0_rxclk (lane0_rxclk),
		.arst_n      (arst_n),
		.half_data   (half_data),
		.half_valid  (half_valid),
		.blk_raw     (blk_raw),
		.blk_valid   (blk_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Block lock and descrambling

	// Slip goes back to the gearbox
	block_sync #(
		.GOOD_FOR_LOCK (GOOD_FOR_LOCK),
		.BAD_LIMIT     (BAD_LIMIT),
		.SLIP_WAIT     (SLIP_WAIT)
	) i_block_sync (
		.lane0_rxclk (lane0_rxclk),
		.arst_n      (arst_n),
		.blk_raw     (blk_raw),
		.blk_valid   (blk_valid),
		.slip        (slip),
		.block_lock  (block_lock)
	);

	descrambler i_descrambler (
		.lane0_rxclk (lane0_rxclk),
		.arst_n      (arst_n),
		.blk_raw     (blk_raw),
		.blk_valid   (blk_valid),
		.rx_block    (rx_block)
	);

endmodule

/* tb_rx_64b66b_sva.sv */
`timescale 1ns/10ps

module tb_rx_64b66b_sva (
	input logic                     lane0_rxclk,
	input logic                     arst_n,
	input logic                     blk_valid,
	input logic                     slip,
	input logic                     block_lock,
	input line_code_pkg::rx_block_t rx_block
);

	// Count of failed assertions
	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// Output strobe and lock rules

	// Blocks come at most every other cycle
	valid_pulse: assert property (@(posedge lane0_rxclk) disable iff (!arst_n)
		rx_block.valid |=> !rx_block.valid) else begin
		$error("rx_block.valid high on two consecutive cycles");
		fail_cnt++;
	end

	// Slip only while hunting
	no_slip_locked: assert property (@(posedge lane0_rxclk) disable iff (!arst_n)
		!(slip && block_lock)) else begin
		$error("slip asserted while block_lock is high");
		fail_cnt++;
	end

	// Descrambler adds exactly one register stage
	valid_latency: assert property (@(posedge lane0_rxclk) disable iff (!arst_n)
		rx_block.valid == $past(blk_valid)) else begin
		$error("rx_block.valid does not follow blk_valid by one cycle");
		fail_cnt++;
	end

	// Outputs held at zero in reset
	reset_idle: assert property (@(posedge lane0_rxclk)
		!arst_n |-> (!block_lock && (rx_block == '0))) else begin
		$error("outputs not low while arst_n is low");
		fail_cnt++;
	end

endmodule

bind rx_64b66b_top tb_rx_64b66b_sva i_rx_64b66b_sva (
	.lane0_rxclk (lane0_rxclk),
	.arst_n      (arst_n),
	.blk_valid   (blk_valid),
	.slip        (slip),
	.block_lock  (block_lock),
	.rx_block    (rx_block)
);

/* tb_rx_64b66b.sv */
`timescale 1ns/10ps

module tb_rx_64b66b;
	import line_code_pkg::*;
	import block_sync_pkg::*;

	localparam int GOOD_FOR_LOCK = DEFAULT_GOOD_FOR_LOCK;
	localparam int BAD_LIMIT     = DEFAULT_BAD_LIMIT;
	localparam int SLIP_WAIT     = DEFAULT_SLIP_WAIT;

	// Test lengths in blocks
	localparam int CLEAN_BLOCKS   = 500;
	localparam int SETTLE_BLOCKS  = 200;
	localparam int BURST_LEN      = 20;
	localparam int PLAN_BLOCKS    = CLEAN_BLOCKS + 2 * SETTLE_BLOCKS + 3 * 64 + BURST_LEN;
	localparam int PLAN_WORDS     = ((PLAN_BLOCKS + 1) * BLOCK_W) / RX_WORD_W + 1;
	// Room for two acquisitions on top of the planned stream
	localparam int TIMEOUT_CYCLES = PLAN_WORDS + 33 * 66 * (GOOD_FOR_LOCK + SLIP_WAIT);

	logic                     lane0_rxclk = 1'b0;
	logic                     arst_n;
	rx_word_t                 rx_data;
	logic                     block_lock;
	rx_block_t                rx_block;

	// Sent blocks before scrambling, in transmit order
	sync_header_t             sent_hdr[$];
	payload_t                 sent_pay[$];
	// Serial line, oldest bit first
	bit                       stream_q[$];
	logic [SCRAMBLER_LEN-1:0] tx_state = '0;

	int                       tests = 0;
	int                       checks = 0;
	int                       errors = 0;
	int                       blk_errors = 0;
	int                       cycles = 0;
	int                       lock_rises = 0;
	int                       lock_drops = 0;
	int                       next_idx = 0;
	int                       k_lock = 0;
	bit                       aligned = 1'b0;
	bit                       skip_first = 1'b0;
	logic                     lock_prev = 1'b0;

	rx_64b66b_top #(
		.GOOD_FOR_LOCK (GOOD_FOR_LOCK),
		.BAD_LIMIT     (BAD_LIMIT),
		.SLIP_WAIT     (SLIP_WAIT)
	) i_dut (
		.lane0_rxclk (lane0_rxclk),
		.arst_n      (arst_n),
		.rx_data     (rx_data),
		.block_lock  (block_lock),
		.rx_block    (rx_block)
	);

	always #2 lane0_rxclk = ~lane0_rxclk;

	//////////////////////////////////////////////////////////////////////
	// Transmit model and reference

	// Bit 0 first, feedback taken from the scrambled output
	function automatic payload_t scramble(input payload_t data);
		payload_t out;
		for (int i = 0; i < PAYLOAD_W; i++) begin
			out[i]   = data[i] ^ tx_state[SCRAMBLER_TAP-1] ^ tx_state[SCRAMBLER_LEN-1];
			tx_state = {tx_state[SCRAMBLER_LEN-2:0], out[i]};
		end
		return out;
	endfunction

	// What the receiver must deliver for sent block idx
	function automatic rx_block_t expected_block(input int idx);
		rx_block_t exp;
		exp.valid   = 1'b1;
		exp.header  = sent_hdr[idx];
		exp.payload = sent_pay[idx];
		return exp;
	endfunction

	function automatic int find_block(input payload_t pay, input int from);
		for (int i = from; i < sent_pay.size(); i++) begin
			if (sent_pay[i] == pay) return i;
		end
		return -1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and reporting

	task automatic check_block(input rx_block_t got, input rx_block_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			blk_errors++;
			$display("Mismatch at %0t: rx_block got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_lock(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic report_test(input int num, input string what, input bit ok);
		tests++;
		$display("Test %0d, %s: %s", num, what, ok ? "ok" : "errors");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Line driver

	// One block onto the line, header first, then every whole word out
	task automatic push_block(input bit bad);
		sync_header_t hdr;
		payload_t     pay;
		line_block_t  blk;
		rx_word_t     word;
		pay = {$urandom, $urandom};
		hdr = ($urandom & 1) ? SH_CTRL : SH_DATA;
		// Illegal headers 00 or 11
		if (bad) hdr = ($urandom & 1) ? 2'b11 : 2'b00;
		sent_hdr.push_back(hdr);
		sent_pay.push_back(pay);
		blk = {hdr, scramble(pay)};
		for (int i = BLOCK_W - 1; i >= 0; i--) stream_q.push_back(blk[i]);
		while (stream_q.size() >= RX_WORD_W) begin
			// First bit on the line lands in the MSB
			for (int i = 0; i < RX_WORD_W; i++) begin
				word = {word[RX_WORD_W-2:0], stream_q.pop_front()};
			end
			@(negedge lane0_rxclk);
			rx_data = word;
		end
	endtask

	// Keep the line busy until block idx has been compared
	task automatic push_until_received(input int idx);
		while (!aligned || (next_idx <= idx)) push_block(1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare process

	always @(negedge lane0_rxclk) begin : compare
		int found;
		if (arst_n) begin
			if (block_lock && !lock_prev) begin
				lock_rises++;
				aligned    = 1'b0;
				// Descrambler history may predate a relock
				skip_first = (lock_rises > 1);
			end
			if (!block_lock && lock_prev) begin
				lock_drops++;
				aligned = 1'b0;
			end
			lock_prev = block_lock;

			if (rx_block.valid && block_lock) begin
				if (skip_first) begin
					skip_first = 1'b0;
				end else begin
					if (!aligned) begin
						found = find_block(rx_block.payload, next_idx);
						if (found < 0) begin
							blk_errors++;
							report_error("received payload matches no sent block");
						end else begin
							aligned  = 1'b1;
							next_idx = found;
							// Lock-declaring block, the window starts after it
							if (lock_rises == 1) k_lock = found;
						end
					end
					if (aligned) begin
						check_block(rx_block, expected_block(next_idx));
						next_idx++;
					end
				end
			end
		end
	end

	// Watchdog
	always @(posedge lane0_rxclk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, expected lock or data never arrived", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		int errs_at;
		int blk_at;
		int first_idx;
		int offset_bits;
		void'($urandom(32'h7e13a95a));
		arst_n  = 1'b1;
		rx_data = '0;
		// Reset falls ahead of the first clock edge
		#1;
		arst_n = 1'b0;

		// Outputs idle during reset
		repeat (4) begin
			@(negedge lane0_rxclk);
			check_lock(block_lock, 1'b0, "block_lock");
			check_lock(rx_block.valid, 1'b0, "rx_block.valid");
		end
		arst_n = 1'b1;
		report_test(1, "outputs low in reset", errors == 0);

		// Random bit offset ahead of the first block
		errs_at     = errors;
		blk_at      = blk_errors;
		offset_bits = $urandom_range(65);
		for (int i = 0; i < offset_bits; i++) stream_q.push_back($urandom & 1);
		while (!aligned) push_block(1'b0);
		first_idx = next_idx;
		repeat (CLEAN_BLOCKS) push_block(1'b0);
		push_until_received(sent_pay.size() - 1);
		check_lock(block_lock, 1'b1, "block_lock");
		if (lock_drops != 0) report_error("block_lock dropped during the clean stream");
		report_test(2, "lock from random offset", (errors - blk_errors) == (errs_at - blk_at));
		report_test(3, "block order and content",
			(blk_errors == blk_at) && (next_idx - first_idx >= CLEAN_BLOCKS));

		// 10 bad headers spread over 64 blocks, below the limit in any window
		errs_at = errors;
		for (int i = 0; i < 64; i++) push_block((i % 6 == 0) && (i < 60));
		repeat (SETTLE_BLOCKS) push_block(1'b0);
		push_until_received(sent_pay.size() - 1);
		check_lock(block_lock, 1'b1, "block_lock");
		if (lock_drops != 0) report_error("block_lock dropped after 10 bad headers");
		report_test(4, "sparse bad headers keep lock", errors == errs_at);

		// Burst placed at the start of a bad header window
		errs_at = errors;
		while ((sent_pay.size() - k_lock - 1) % 64 != 0) push_block(1'b0);
		repeat (BURST_LEN) push_block(1'b1);
		repeat (10) push_block(1'b0);
		check_lock(block_lock, 1'b0, "block_lock");
		while ((lock_rises < 2) || !aligned) push_block(1'b0);
		repeat (SETTLE_BLOCKS) push_block(1'b0);
		push_until_received(sent_pay.size() - 1);
		check_lock(block_lock, 1'b1, "block_lock");
		report_test(5, "burst drops lock then relock", errors == errs_at);

		$display("Totals: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, i_dut.i_rx_64b66b_sva.fail_cnt);
		if ((errors == 0) && (i_dut.i_rx_64b66b_sva.fail_cnt == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* flist.f */
line_code_pkg.sv
block_sync_pkg.sv
rx_gearbox.sv
half_block_assembler.sv
block_sync.sv
descrambler.sv
rx_64b66b_top.sv
tb_rx_64b66b_sva.sv
tb_rx_64b66b.sv
